//--- common/afifo_pkg.sv
package afifo_pkg;

   // port widths, write side is the wide one
   localparam int W_DATA_W  = 32;
   localparam int R_DATA_W  = 8;

   // byte addressing, 64 bytes of storage
   localparam int ADDR_W    = 6;
   localparam int RATIO_LOG = 2;
   localparam int W_ADDR_W  = ADDR_W - RATIO_LOG;
   localparam int FIFO_BYTES = 1 << ADDR_W;

   typedef logic [W_DATA_W-1:0] wdata_t;
   typedef logic [R_DATA_W-1:0] rdata_t;

   // pointers carry one extra wrap bit on top
   typedef logic [W_ADDR_W:0] wptr_t;
   typedef logic [ADDR_W:0]   rptr_t;

   // fill level in bytes, 0 up to FIFO_BYTES
   typedef logic [ADDR_W:0]   level_t;

   // wishbone classic write request from the master
   typedef struct packed {
      logic   cyc;
      logic   stb;
      logic   we;
      wdata_t dat;
   } wb_wr_req_t;

   // read request, data goes back on a separate port
   typedef struct packed {
      logic cyc;
      logic stb;
      logic we;
   } wb_rd_req_t;

   typedef enum logic [1:0] {
      W_INIT,
      W_IDLE,
      W_ACK
   } wr_state_t;

   typedef enum logic [1:0] {
      R_INIT,
      R_IDLE,
      R_ACK
   } rd_state_t;

endpackage

//--- fifo/gray_ptr_counter.sv
module gray_ptr_counter #(
   parameter int PTR_W = 5
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic             en_i,
   output logic [PTR_W-1:0] bin_o,
   output logic [PTR_W-1:0] gray_o
);

   logic [PTR_W-1:0] bin_q;
   logic [PTR_W-1:0] bin_next;
   logic [PTR_W-1:0] gray_q;

   assign bin_next = bin_q + PTR_W'(1);

   // gray copy is registered so the crossing sees one bit flip per step
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         bin_q  <= '0;
         gray_q <= '0;
      end else if (en_i) begin
         bin_q  <= bin_next;
         gray_q <= bin_next ^ (bin_next >> 1);
      end
   end

   assign bin_o  = bin_q;
   assign gray_o = gray_q;

endmodule

//--- fifo/ptr_sync.sv
module ptr_sync #(
   parameter int PTR_W = 5
) (
   input  logic             clk_i,
   input  logic             rst_n_i,
   input  logic [PTR_W-1:0] gray_i,
   output logic [PTR_W-1:0] bin_o
);

   logic [PTR_W-1:0] meta_q;
   logic [PTR_W-1:0] sync_q;

   // two stages in the local clock
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         meta_q <= '0;
         sync_q <= '0;
      end else begin
         meta_q <= gray_i;
         sync_q <= meta_q;
      end
   end

   // each binary bit is the xor of all gray bits at and above it
   always_comb begin
      for (int i = 0; i < PTR_W; i++) begin
         bin_o[i] = ^(sync_q >> i);
      end
   end

endmodule

//--- fifo/asym_dpram.sv
module asym_dpram
   import afifo_pkg::*;
(
   input  logic                w_clk_i,
   input  logic                w_en_i,
   input  logic [W_ADDR_W-1:0] w_addr_i,
   input  wdata_t              w_data_i,

   input  logic                r_clk_i,
   input  logic                r_en_i,
   input  logic [ADDR_W-1:0]   r_addr_i,
   output rdata_t              r_data_o
);

   // one entry per word
   wdata_t mem [FIFO_BYTES >> RATIO_LOG];

   logic [W_ADDR_W-1:0]  r_word;
   logic [RATIO_LOG-1:0] r_lane;
   wdata_t               r_word_data;

   always_ff @(posedge w_clk_i) begin
      if (w_en_i) begin
         mem[w_addr_i] <= w_data_i;
      end
   end

   // upper byte address bits pick the word, lower ones the lane
   assign r_word      = r_addr_i[ADDR_W-1:RATIO_LOG];
   assign r_lane      = r_addr_i[RATIO_LOG-1:0];
   assign r_word_data = mem[r_word];

   // lane 0 is the least significant byte
   always_ff @(posedge r_clk_i) begin
      if (r_en_i) begin
         r_data_o <= r_word_data[r_lane*R_DATA_W +: R_DATA_W];
      end
   end

endmodule

//--- fifo/fifo_wr_ctrl.sv
module fifo_wr_ctrl
   import afifo_pkg::*;
(
   input  logic       w_clk_i,
   input  logic       rst_n_i,
   input  wb_wr_req_t wb_i,
   input  wptr_t      w_ptr_i,
   input  rptr_t      r_ptr_sync_i,
   output logic       ack_o,
   output logic       w_en_o,
   output logic       w_full_o,
   output level_t     w_level_o
);

   wr_state_t state_q;
   wr_state_t state_d;
   level_t    level;
   logic      full;
   logic      req;

   // word pointer scaled to bytes, wrap bit keeps 64 apart from 0
   assign level = {w_ptr_i, {RATIO_LOG{1'b0}}} - r_ptr_sync_i;

   // full once a whole word no longer fits
   assign full = level > level_t'(FIFO_BYTES - (1 << RATIO_LOG));

   assign req = wb_i.cyc & wb_i.stb & wb_i.we;

   always_comb begin
      state_d   = state_q;
      w_en_o    = 1'b0;
      w_full_o  = 1'b0;
      w_level_o = '0;
      case (state_q)
         W_INIT: begin
            state_d = W_IDLE;
         end
         W_IDLE: begin
            w_full_o  = full;
            w_level_o = level;
            if (req && !full) begin
               w_en_o  = 1'b1;
               state_d = W_ACK;
            end
         end
         W_ACK: begin
            // master still holds stb here, no new write this cycle
            w_full_o  = full;
            w_level_o = level;
            state_d   = W_IDLE;
         end
         default: begin
            state_d = W_INIT;
         end
      endcase
   end

   always_ff @(posedge w_clk_i) begin
      if (!rst_n_i) begin
         state_q <= W_INIT;
      end else begin
         state_q <= state_d;
      end
   end

   assign ack_o = (state_q == W_ACK);

endmodule

//--- fifo/fifo_rd_ctrl.sv
module fifo_rd_ctrl
   import afifo_pkg::*;
(
   input  logic       r_clk_i,
   input  logic       rst_n_i,
   input  wb_rd_req_t wb_i,
   input  rptr_t      r_ptr_i,
   input  wptr_t      w_ptr_sync_i,
   output logic       ack_o,
   output logic       r_en_o,
   output logic       r_empty_o,
   output level_t     r_level_o
);

   rd_state_t state_q;
   rd_state_t state_d;
   level_t    level;
   logic      empty;
   logic      req;

   // synced word pointer in bytes against the local byte pointer
   assign level = {w_ptr_sync_i, {RATIO_LOG{1'b0}}} - r_ptr_i;
   assign empty = (level == '0);

   assign req = wb_i.cyc & wb_i.stb & ~wb_i.we;

   always_comb begin
      state_d   = state_q;
      r_en_o    = 1'b0;
      r_empty_o = 1'b1;
      r_level_o = '0;
      case (state_q)
         R_INIT: begin
            state_d = R_IDLE;
         end
         R_IDLE: begin
            r_empty_o = empty;
            r_level_o = level;
            // ram output register loads here, byte is valid in R_ACK
            if (req && !empty) begin
               r_en_o  = 1'b1;
               state_d = R_ACK;
            end
         end
         R_ACK: begin
            r_empty_o = empty;
            r_level_o = level;
            state_d   = R_IDLE;
         end
         default: begin
            state_d = R_INIT;
         end
      endcase
   end

   always_ff @(posedge r_clk_i) begin
      if (!rst_n_i) begin
         state_q <= R_INIT;
      end else begin
         state_q <= state_d;
      end
   end

   assign ack_o = (state_q == R_ACK);

endmodule

//--- source/wb_afifo_top.sv
module wb_afifo_top
   import afifo_pkg::*;
(
   input  logic       w_clk_i,
   input  logic       r_clk_i,
   input  logic       rst_n_i,

   // write port
   input  wb_wr_req_t wb_wr_i,
   output logic       wb_wr_ack_o,
   output logic       w_full_o,
   output level_t     w_level_o,

   // read port
   input  wb_rd_req_t wb_rd_i,
   output logic       wb_rd_ack_o,
   output rdata_t     wb_rd_dat_o,
   output logic       r_empty_o,
   output level_t     r_level_o
);

   logic  w_en;
   logic  r_en;

   // pointers in their own domain
   wptr_t w_ptr_bin;
   wptr_t w_ptr_gray;
   rptr_t r_ptr_bin;
   rptr_t r_ptr_gray;

   // pointers after crossing
   wptr_t r_wptr_sync;
   rptr_t w_rptr_sync;

   fifo_wr_ctrl u_wr_ctrl (
      .w_clk_i      (w_clk_i),
      .rst_n_i      (rst_n_i),
      .wb_i         (wb_wr_i),
      .w_ptr_i      (w_ptr_bin),
      .r_ptr_sync_i (w_rptr_sync),
      .ack_o        (wb_wr_ack_o),
      .w_en_o       (w_en),
      .w_full_o     (w_full_o),
      .w_level_o    (w_level_o)
   );

   fifo_rd_ctrl u_rd_ctrl (
      .r_clk_i      (r_clk_i),
      .rst_n_i      (rst_n_i),
      .wb_i         (wb_rd_i),
      .r_ptr_i      (r_ptr_bin),
      .w_ptr_sync_i (r_wptr_sync),
      .ack_o        (wb_rd_ack_o),
      .r_en_o       (r_en),
      .r_empty_o    (r_empty_o),
      .r_level_o    (r_level_o)
   );

   gray_ptr_counter #(.PTR_W(W_ADDR_W+1)) u_w_ptr (
      .clk_i   (w_clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (w_en),
      .bin_o   (w_ptr_bin),
      .gray_o  (w_ptr_gray)
   );

   gray_ptr_counter #(.PTR_W(ADDR_W+1)) u_r_ptr (
      .clk_i   (r_clk_i),
      .rst_n_i (rst_n_i),
      .en_i    (r_en),
      .bin_o   (r_ptr_bin),
      .gray_o  (r_ptr_gray)
   );

   // write pointer into the read clock
   ptr_sync #(.PTR_W(W_ADDR_W+1)) u_w2r_sync (
      .clk_i   (r_clk_i),
      .rst_n_i (rst_n_i),
      .gray_i  (w_ptr_gray),
      .bin_o   (r_wptr_sync)
   );

   // read pointer into the write clock
   ptr_sync #(.PTR_W(ADDR_W+1)) u_r2w_sync (
      .clk_i   (w_clk_i),
      .rst_n_i (rst_n_i),
      .gray_i  (r_ptr_gray),
      .bin_o   (w_rptr_sync)
   );

   asym_dpram u_ram (
      .w_clk_i  (w_clk_i),
      .w_en_i   (w_en),
      .w_addr_i (w_ptr_bin[W_ADDR_W-1:0]),
      .w_data_i (wb_wr_i.dat),
      .r_clk_i  (r_clk_i),
      .r_en_i   (r_en),
      .r_addr_i (r_ptr_bin[ADDR_W-1:0]),
      .r_data_o (wb_rd_dat_o)
   );

endmodule

//--- tests/tb_clk_gen.sv
module tb_clk_gen #(
   parameter real PHASE_NS = 0.0
) (
   output logic clk_o
);

   timeunit 1ns;
   timeprecision 1ps;

   // 4 ns period
   localparam real HALF_NS = 2.0;

   initial begin
      clk_o = 1'b0;
      #(PHASE_NS);
      forever begin
         #(HALF_NS);
         clk_o = ~clk_o;
      end
   end

endmodule

//--- tests/wb_afifo_tb.sv
module wb_afifo_tb
   import afifo_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int N_RAND_WORDS = 200;
   // two byte order words, 17 for full, one for empty, then the random run
   localparam int N_WORDS      = 2 + 17 + 1 + N_RAND_WORDS;
   localparam int N_TRANSFERS  = N_WORDS * 5;
   localparam int HS_LIMIT     = 400;
   // full above 60 bytes
   localparam int FULL_MARK    = 60;

   logic        w_clk;
   logic        r_clk;
   logic        rst_n;
   wb_wr_req_t  wb_wr;
   wb_rd_req_t  wb_rd;
   logic        w_ack;
   logic        w_full;
   level_t      w_level;
   logic        r_ack;
   rdata_t      r_dat;
   logic        r_empty;
   level_t      r_level;
   logic        w_req;
   logic        r_req;

   // expected bytes in write order, the read side walks it by index
   rdata_t      sb_q[$];
   int          wr_bytes = 0;
   int          rd_bytes = 0;
   int          in_flight;
   rdata_t      exp_byte = '0;
   logic        exp_valid = 1'b0;
   int          wr_errors = 0;
   int          rd_errors = 0;
   int          run_errors = 0;
   logic [31:0] wr_seed;
   logic [31:0] rd_seed;

   tb_clk_gen #(.PHASE_NS(0.0)) w_clk_gen (.clk_o(w_clk));
   tb_clk_gen #(.PHASE_NS(1.3)) r_clk_gen (.clk_o(r_clk));

   wb_afifo_top DUT (
      .w_clk_i     (w_clk),
      .r_clk_i     (r_clk),
      .rst_n_i     (rst_n),
      .wb_wr_i     (wb_wr),
      .wb_wr_ack_o (w_ack),
      .w_full_o    (w_full),
      .w_level_o   (w_level),
      .wb_rd_i     (wb_rd),
      .wb_rd_ack_o (r_ack),
      .wb_rd_dat_o (r_dat),
      .r_empty_o   (r_empty),
      .r_level_o   (r_level)
   );

   assign w_req     = wb_wr.cyc & wb_wr.stb & wb_wr.we;
   assign r_req     = wb_rd.cyc & wb_rd.stb & ~wb_rd.we;
   assign in_flight = wr_bytes - rd_bytes;

   // numerical recipes constants
   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic note_wr_error(input string msg);
      wr_errors++;
      $display("** Error at %0t ns: %s", $time, msg);
   endtask

   task automatic note_rd_error(input string msg);
      rd_errors++;
      $display("** Error at %0t ns: %s", $time, msg);
   endtask

   task automatic print_counts();
      $display("words %0d, bytes %0d, write errors %0d, read errors %0d, run errors %0d",
               wr_bytes >> RATIO_LOG, rd_bytes, wr_errors, rd_errors, run_errors);
   endtask

   // dat is still held by the master during the ack cycle
   always @(negedge w_clk) begin
      if (rst_n && w_ack) begin
         for (int k = 0; k < (1 << RATIO_LOG); k++) begin
            sb_q.push_back(wb_wr.dat[k*R_DATA_W +: R_DATA_W]);
         end
         wr_bytes <= wr_bytes + (1 << RATIO_LOG);
      end
   end

   // next expected byte is ready half a cycle before ack is sampled
   always @(negedge r_clk) begin
      if (rst_n && r_ack) begin
         if (rd_bytes < sb_q.size()) begin
            exp_valid <= 1'b1;
            exp_byte  <= sb_q[rd_bytes];
         end else begin
            exp_valid <= 1'b0;
         end
         rd_bytes <= rd_bytes + 1;
      end
   end

   wr_reset_state: assert property (@(posedge w_clk)
      !rst_n |=> (!w_ack && !w_full && w_level == '0))
      else note_wr_error("write side not idle and empty after reset");
   wr_ack_in_cycle: assert property (@(posedge w_clk) disable iff (!rst_n)
      w_ack |-> w_req)
      else note_wr_error("write ack without a write request");
   wr_ack_pulse: assert property (@(posedge w_clk) disable iff (!rst_n)
      w_ack |=> !w_ack)
      else note_wr_error("write ack longer than one cycle");
   wr_hold_when_full: assert property (@(posedge w_clk) disable iff (!rst_n)
      (w_full && w_req && !w_ack) |=> !w_ack)
      else note_wr_error("write acknowledged while full");
   wr_full_flag: assert property (@(posedge w_clk) disable iff (!rst_n)
      w_full == (int'(w_level) > FULL_MARK))
      else note_wr_error($sformatf("full %0b at level %0d", w_full, w_level));
   // write side sees reads late, so its level can only be high
   wr_level_range: assert property (@(posedge w_clk) disable iff (!rst_n)
      int'(w_level) <= FIFO_BYTES && int'(w_level) >= in_flight)
      else note_wr_error($sformatf("write level %0d, in flight %0d", w_level, in_flight));

   rd_reset_state: assert property (@(posedge r_clk)
      !rst_n |=> (!r_ack && r_empty && r_level == '0))
      else note_rd_error("read side not idle and empty after reset");
   rd_ack_in_cycle: assert property (@(posedge r_clk) disable iff (!rst_n)
      r_ack |-> r_req)
      else note_rd_error("read ack without a read request");
   rd_ack_pulse: assert property (@(posedge r_clk) disable iff (!rst_n)
      r_ack |=> !r_ack)
      else note_rd_error("read ack longer than one cycle");
   rd_hold_when_empty: assert property (@(posedge r_clk) disable iff (!rst_n)
      (r_empty && r_req && !r_ack) |=> !r_ack)
      else note_rd_error("read acknowledged while empty");
   rd_empty_flag: assert property (@(posedge r_clk) disable iff (!rst_n)
      r_empty == (r_level == '0))
      else note_rd_error($sformatf("empty %0b at level %0d", r_empty, r_level));
   rd_level_range: assert property (@(posedge r_clk) disable iff (!rst_n)
      int'(r_level) <= FIFO_BYTES && int'(r_level) <= in_flight)
      else note_rd_error($sformatf("read level %0d, in flight %0d", r_level, in_flight));
   rd_byte_order: assert property (@(posedge r_clk) disable iff (!rst_n)
      r_ack |-> (exp_valid && r_dat == exp_byte))
      else note_rd_error($sformatf("read byte %h, expected %h", r_dat, exp_byte));

   task automatic write_word(input wdata_t data);
      int waited;
      waited = 0;
      @(posedge w_clk);
      #0.5;
      wb_wr.cyc = 1'b1;
      wb_wr.stb = 1'b1;
      wb_wr.we  = 1'b1;
      wb_wr.dat = data;
      @(negedge w_clk);
      while (!w_ack && waited < HS_LIMIT) begin
         waited++;
         @(negedge w_clk);
      end
      if (!w_ack) begin
         run_errors++;
         $display("write of word %h got no ack within %0d cycles", data, HS_LIMIT);
      end
      @(posedge w_clk);
      #0.5;
      wb_wr.cyc = 1'b0;
      wb_wr.stb = 1'b0;
      wb_wr.we  = 1'b0;
   endtask

   task automatic read_byte();
      int waited;
      waited = 0;
      @(posedge r_clk);
      #0.5;
      wb_rd.cyc = 1'b1;
      wb_rd.stb = 1'b1;
      wb_rd.we  = 1'b0;
      @(negedge r_clk);
      while (!r_ack && waited < HS_LIMIT) begin
         waited++;
         @(negedge r_clk);
      end
      if (!r_ack) begin
         run_errors++;
         $display("read got no ack within %0d cycles", HS_LIMIT);
      end
      @(posedge r_clk);
      #0.5;
      wb_rd.cyc = 1'b0;
      wb_rd.stb = 1'b0;
   endtask

   // slowest case per transfer plus margin
   initial begin
      #(N_TRANSFERS * 40 + 2000);
      $display("watchdog expired, the test sequence did not finish in time");
      print_counts();
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      int waited;
      rst_n   = 1'b0;
      wb_wr   = '0;
      wb_rd   = '0;
      wr_seed = 32'd76680;
      rd_seed = lcg_next(32'd76680);
      repeat (4) @(posedge w_clk);
      #0.5;
      rst_n = 1'b1;
      // quiet ports after reset
      repeat (10) @(posedge w_clk);

      write_word(32'h4433_2211);
      write_word(32'h8877_6655);
      repeat (8) read_byte();

      // reader idle until full
      for (int i = 0; i < 16; i++) begin
         wr_seed = lcg_next(wr_seed);
         write_word(wr_seed);
      end
      waited = 0;
      while (!w_full && waited < 8) begin
         @(negedge w_clk);
         waited++;
      end
      if (!w_full) begin
         run_errors++;
         $display("full flag did not rise after 16 writes");
      end
      fork
         begin
            wr_seed = lcg_next(wr_seed);
            write_word(wr_seed);
         end
         begin
            repeat (12) @(posedge r_clk);
            repeat (4) read_byte();
         end
      join
      repeat (64) read_byte();

      // read waits on an empty FIFO
      fork
         read_byte();
         begin
            repeat (20) @(posedge w_clk);
            write_word(32'ha5c3_0f96);
         end
      join
      repeat (3) read_byte();

      fork
         begin
            for (int i = 0; i < N_RAND_WORDS; i++) begin
               wr_seed = lcg_next(wr_seed);
               repeat (int'(wr_seed[17:16])) @(posedge w_clk);
               wr_seed = lcg_next(wr_seed);
               write_word(wr_seed);
            end
         end
         begin
            for (int j = 0; j < N_RAND_WORDS * 4; j++) begin
               rd_seed = lcg_next(rd_seed);
               repeat (int'(rd_seed[17:16])) @(posedge r_clk);
               read_byte();
            end
         end
      join

      repeat (10) @(posedge r_clk);
      if (rd_bytes != sb_q.size()) begin
         run_errors++;
         $display("%0d bytes were written but %0d were read", sb_q.size(), rd_bytes);
      end
      print_counts();
      if (wr_errors + rd_errors + run_errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

//--- list.f
common/afifo_pkg.sv
fifo/gray_ptr_counter.sv
fifo/ptr_sync.sv
fifo/asym_dpram.sv
fifo/fifo_wr_ctrl.sv
fifo/fifo_rd_ctrl.sv
source/wb_afifo_top.sv
tests/tb_clk_gen.sv
tests/wb_afifo_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the FIFO testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module wb_afifo_tb -f list.f -o wb_afifo_sim \
   && ./obj_dir/wb_afifo_sim > sim.log 2>&1 \
   ; cat sim.log 2>/dev/null

# result is taken from the log only
grep -q "TEST PASSED" sim.log \
   && echo "simulation result: pass" \
   || { echo "simulation result: fail"; exit 1; }
